/* Makefile */
# Verilator flow for the bkVideo video output subsystem

OBJ_DIR = obj_dir

.PHONY: lint sim clean

# RTL top level only
lint:
	verilator --lint-only --timing -f bkVideo.f --top-module bkVideo

# Build and run the testbench, then look for the pass line in the log
sim:
	verilator --binary -j 0 -f bkVideo.f --top-module bkVideoTb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/VbkVideoTb | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

/* bench/bkVideoTb.sv */
`include "bkVideo_params.svh"

module bkVideoTb
   import bkVideoPkg::*;
();

   // Three full frames plus some slack
   localparam int TIMEOUT_CYCLES = 3 * `H_TOTAL * `V_TOTAL + 100;

   logic        clk;
   logic        rstN;
   logic [7:0]  rollOffset;
   logic        colorMode;
   logic        ramRd;
   vramAddr     ramAddr;
   logic [15:0] ramData;
   videoOut     video;

   // Frame buffer contents with one word per address
   logic [15:0] mem [0:8191];

   // Model state
   logic [7:0]  frameRoll;
   logic        frameColor;
   screenWord   rowWords [0:31];
   videoOut     expQ [$];
   logic        readPending;
   vramAddr     pendingAddr;
   int          errors;
   int          cycleCount;

   bkVideo bkVideo_i (
      .clk        (clk),
      .rstN       (rstN),
      .rollOffset (rollOffset),
      .colorMode  (colorMode),
      .ramRd      (ramRd),
      .ramAddr    (ramAddr),
      .ramData    (ramData),
      .video      (video)
   );

   // ==========================================================================
   // Clock and cycle limit
   // ==========================================================================

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial cycleCount = 0;

   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Verification failed");
         $fatal(1, "simulation stopped by cycle limit");
      end
   end

   // ==========================================================================
   // Compare tasks
   // ==========================================================================

   task automatic abortRun();
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic checkPixel(input string name, input rgbPixel exp, input rgbPixel act);
      if (act !== exp) begin
         errors++;
         $display("error at %0t: %s expected rgb %b, got rgb %b", $time, name, exp, act);
         abortRun();
      end
   endtask

   task automatic checkSync(input string name, input syncBits exp, input syncBits act);
      if (act !== exp) begin
         errors++;
         $display("error at %0t: %s expected hv %b, got hv %b", $time, name, exp, act);
         abortRun();
      end
   endtask

   task automatic checkAddr(input string name, input vramAddr exp, input vramAddr act);
      if (act !== exp) begin
         errors++;
         $display("error at %0t: %s expected row %0d col %0d, got row %0d col %0d",
                  $time, name, exp.row, exp.col, act.row, act.col);
         abortRun();
      end
   endtask

   task automatic checkActive(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
         abortRun();
      end
   endtask

   // ==========================================================================
   // RAM and reference model
   // ==========================================================================

   // Word shows up on the clock after the strobe and random junk on other clocks
   task automatic serveRam();
      if (readPending)
         ramData = mem[pendingAddr];
      else
         ramData = 16'($urandom);
      readPending = ramRd;
      pendingAddr = ramAddr;
   endtask

   // Mono bit or colour field for one pixel of a word
   function automatic rgbPixel pixelFor(screenWord w, int x, logic colorFrame);
      rgbPixel    p;
      logic [1:0] field;
      logic       bitVal;
      p = '0;
      if (colorFrame) begin
         field = w.color[3'((x % 16) / 2)];
         case (field)
            2'b01:   p.b = 1'b1;
            2'b10:   p.g = 1'b1;
            2'b11:   p.r = 1'b1;
            default: p = '0;
         endcase
      end else begin
         bitVal = w.mono[4'(x % 16)];
         p = '{r: bitVal, g: bitVal, b: bitVal};
      end
      return p;
   endfunction

   // Strobe two clocks ahead of each word and for column 0 on the line before
   task automatic checkFetch(input int x, input int y);
      int      tLine;
      int      col;
      logic    expRd;
      vramAddr expAddr;
      expRd = 1'b0;
      tLine = 0;
      col   = 0;
      if (x == `H_TOTAL - 2) begin
         tLine = (y == `V_TOTAL - 1) ? 0 : y + 1;
         expRd = (tLine < `V_VISIBLE);
      end else if ((x % 16 == 14) && (x + 2 < `H_VISIBLE)) begin
         tLine = y;
         col   = (x + 2) / 16;
         expRd = (y < `V_VISIBLE);
      end
      checkActive("ramRd", expRd, ramRd);
      if (expRd) begin
         // Two display lines per row with the roll wrapping at 256
         expAddr.row = 8'(tLine / 2 + int'(frameRoll));
         expAddr.col = 5'(col);
         checkAddr("ramAddr", expAddr, ramAddr);
         rowWords[5'(col)] = mem[expAddr];
      end
   endtask

   // Output now belongs to the position three clocks back
   task automatic checkOutput(input int x, input int y);
      videoOut expNow;
      videoOut expDue;
      expNow = '0;
      expNow.active     = (x < `H_VISIBLE) && (y < `V_VISIBLE);
      expNow.sync.hSync = !((x >= `HSYNC_FIRST) && (x <= `HSYNC_LAST));
      expNow.sync.vSync = (y != `VSYNC_LINE);
      if (expNow.active)
         expNow.pixel = pixelFor(rowWords[5'(x / 16)], x, frameColor);
      expQ.push_back(expNow);
      expDue = expQ.pop_front();
      checkPixel("video.pixel", expDue.pixel, video.pixel);
      checkSync("video.sync", expDue.sync, video.sync);
      checkActive("video.active", expDue.active, video.active);
   endtask

   // ==========================================================================
   // Stimulus
   // ==========================================================================

   initial begin
      videoOut idleOut;
      int      changeLine;
      int      changeX;
      void'($urandom(32'hec4a_2217));
      errors      = 0;
      rstN        = 1'b0;
      ramData     = '0;
      readPending = 1'b0;
      pendingAddr = '0;
      frameRoll   = '0;
      frameColor  = 1'b0;
      rollOffset  = 8'($urandom);
      colorMode   = 1'($urandom);
      for (int i = 0; i < 8192; i++) begin
         mem[13'(i)] = 16'($urandom);
      end
      // Nothing fetched yet for line 0 of the first frame
      for (int i = 0; i < 32; i++) begin
         rowWords[5'(i)] = '0;
      end
      idleOut      = '0;
      idleOut.sync = '1;
      repeat (`PIPE_DELAY) expQ.push_back(idleOut);

      repeat (4) @(posedge clk);
      @(negedge clk);
      // Reset state is black and idle
      checkPixel("video.pixel", idleOut.pixel, video.pixel);
      checkSync("video.sync", idleOut.sync, video.sync);
      checkActive("video.active", 1'b0, video.active);
      checkActive("ramRd", 1'b0, ramRd);
      rstN = 1'b1;

      for (int frame = 0; frame < 3; frame++) begin
         // Mid-frame change point that applies from the next frame
         changeLine = $urandom_range(16, 500);
         changeX    = $urandom_range(0, `H_TOTAL - 1);
         for (int y = 0; y < `V_TOTAL; y++) begin
            for (int x = 0; x < `H_TOTAL; x++) begin
               if ((x == changeX) && (y == changeLine)) begin
                  rollOffset = rollOffset + 8'd1 + 8'($urandom_range(0, 254));
                  colorMode  = !colorMode;
               end
               // Frame start sample
               if ((x == 0) && (y == 0)) begin
                  frameRoll  = rollOffset;
                  frameColor = colorMode;
               end
               serveRam();
               checkFetch(x, y);
               checkOutput(x, y);
               @(negedge clk);
            end
         end
      end

      if (errors == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("Verification failed");
         $fatal(1, "run ended with mismatches");
      end
   end

endmodule

/* bkVideo.f */
+incdir+common
common/bkVideoPkg.sv
design/syncGen.sv
design/videoFetch.sv
shifter/pixelShifter.sv
design/bkVideo.sv
bench/bkVideoTb.sv

/* common/bkVideoPkg.sv */
package bkVideoPkg;

   // ==========================================================================
   // Raster position and sync
   // ==========================================================================

   // Beam position from the timing generator
   typedef struct packed {
      logic [9:0] x;
      logic [9:0] y;
      logic       visible;   // x below 512 and y below 512
   } beamPos;

   // Both syncs active low
   typedef struct packed {
      logic hSync;
      logic vSync;
   } syncBits;

   // ==========================================================================
   // Video RAM and pixel data
   // ==========================================================================

   // Word address into the 16 KB frame buffer
   typedef struct packed {
      logic [7:0] row;   // rolled memory row
      logic [4:0] col;   // word within the row
   } vramAddr;

   // One screen word seen either as mono bits or as colour fields
   typedef union packed {
      logic [15:0]      mono;    // bit 0 is the leftmost pixel
      logic [7:0][1:0]  color;   // field 0 is the leftmost pixel
   } screenWord;

   typedef struct packed {
      logic r;
      logic g;
      logic b;
   } rgbPixel;

   // Output bundle of the subsystem
   typedef struct packed {
      rgbPixel pixel;
      syncBits sync;
      logic    active;
   } videoOut;

endpackage

/* common/bkVideo_params.svh */
`ifndef BKVIDEO_PARAMS_SVH
`define BKVIDEO_PARAMS_SVH

// ==========================================================================
// Raster timing for the 25 MHz pixel clock
// ==========================================================================

// Clocks per line and lines per frame
`define H_TOTAL       700
`define V_TOTAL       626

// Visible window in clocks and display lines
`define H_VISIBLE     512
`define V_VISIBLE     512

// Horizontal sync low for x in this range, both ends inclusive
`define HSYNC_FIRST   566
`define HSYNC_LAST    589

// Vertical sync low for this whole line
`define VSYNC_LINE    554

// Screen words per 64-byte memory row
`define WORDS_PER_ROW 32

// Counter position to output pixel, in clocks
`define PIPE_DELAY    3

`endif

/* design/bkVideo.sv */
module bkVideo
   import bkVideoPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  logic [7:0]  rollOffset,
   input  logic        colorMode,
   output logic        ramRd,
   output vramAddr     ramAddr,
   input  logic [15:0] ramData,
   output videoOut     video
);

   // Raster position and raw sync
   beamPos    pos;
   syncBits   sync;

   // Fetch to shifter
   logic      load;
   screenWord fetched;
   logic      color;

   // ==========================================================================
   // Timing, fetch and shifter
   // ==========================================================================

   syncGen syncGen_i (
      .clk  (clk),
      .rstN (rstN),
      .pos  (pos),
      .sync (sync)
   );

   videoFetch videoFetch_i (
      .clk        (clk),
      .rstN       (rstN),
      .pos        (pos),
      .rollOffset (rollOffset),
      .colorMode  (colorMode),
      .ramRd      (ramRd),
      .ramAddr    (ramAddr),
      .ramData    (ramData),
      .load       (load),
      .fetched    (fetched),
      .color      (color)
   );

   pixelShifter pixelShifter_i (
      .clk     (clk),
      .rstN    (rstN),
      .pos     (pos),
      .sync    (sync),
      .load    (load),
      .fetched (fetched),
      .color   (color),
      .video   (video)
   );

endmodule

/* design/syncGen.sv */
`include "bkVideo_params.svh"

module syncGen
   import bkVideoPkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   output beamPos  pos,
   output syncBits sync
);

   // ==========================================================================
   // Beam counters
   // ==========================================================================

   logic [9:0] xCnt;
   logic [9:0] yCnt;

   // Wrap flags, set one clock ahead of the wrap
   logic       lineEnd;
   logic       frameEnd;

   // Compares registered so the counters see a single flop
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         lineEnd  <= 1'b0;
         frameEnd <= 1'b0;
      end else begin
         lineEnd  <= (xCnt == 10'(`H_TOTAL - 2));
         // Last clock of the last line
         frameEnd <= (xCnt == 10'(`H_TOTAL - 2)) && (yCnt == 10'(`V_TOTAL - 1));
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         xCnt <= '0;
         yCnt <= '0;
      end else begin
         if (lineEnd)
            xCnt <= '0;
         else
            xCnt <= xCnt + 10'd1;

         // Line step on the x wrap
         if (frameEnd)
            yCnt <= '0;
         else if (lineEnd)
            yCnt <= yCnt + 10'd1;
      end
   end

   // ==========================================================================
   // Sync and visible window
   // ==========================================================================

   // Sync levels one clock behind the counters
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         sync.hSync <= 1'b1;
         sync.vSync <= 1'b1;
      end else begin
         sync.hSync <= !((xCnt >= 10'(`HSYNC_FIRST)) && (xCnt <= 10'(`HSYNC_LAST)));
         sync.vSync <= (yCnt != 10'(`VSYNC_LINE));
      end
   end

   // Position and window aligned with the counters
   assign pos.x       = xCnt;
   assign pos.y       = yCnt;
   assign pos.visible = (xCnt < 10'(`H_VISIBLE)) && (yCnt < 10'(`V_VISIBLE));

   // Counters stay inside the raster
   counterRange: assert property (@(posedge clk) disable iff (!rstN)
      (xCnt < 10'(`H_TOTAL)) && (yCnt < 10'(`V_TOTAL)))
      else $error("beam counter out of range x=%0d y=%0d", xCnt, yCnt);

   // Frame wraps to the origin from the last clock of line 625
   frameWrap: assert property (@(posedge clk) disable iff (!rstN)
      (xCnt == 10'(`H_TOTAL - 1)) && (yCnt == 10'(`V_TOTAL - 1))
      |=> (xCnt == '0) && (yCnt == '0))
      else $error("frame did not wrap to origin");

endmodule

/* design/videoFetch.sv */
`include "bkVideo_params.svh"

module videoFetch
   import bkVideoPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  beamPos      pos,
   input  logic [7:0]  rollOffset,
   input  logic        colorMode,
   output logic        ramRd,
   output vramAddr     ramAddr,
   input  logic [15:0] ramData,
   output logic        load,
   output screenWord   fetched,
   output logic        color
);

   logic [7:0] frameRoll;
   logic       frameStart;
   logic       wrapAhead;
   logic [9:0] aheadX;
   logic [9:0] aheadY;
   logic       strobeNext;
   logic [7:0] rowNext;

   // ==========================================================================
   // Per-frame roll and mode
   // ==========================================================================

   assign frameStart = (pos.x == '0) && (pos.y == '0);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         frameRoll <= '0;
         color     <= 1'b0;
      end else if (frameStart) begin
         frameRoll <= rollOffset;
         color     <= colorMode;
      end
   end

   // ==========================================================================
   // Look-ahead strobe decode
   // ==========================================================================

   // Strobe flop adds one clock, so decode three clocks ahead of the first pixel
   assign wrapAhead = (pos.x >= 10'(`H_TOTAL - 3));
   assign aheadX    = wrapAhead ? pos.x - 10'(`H_TOTAL - 3) : pos.x + 10'd3;

   // Target line moves to the next one past the line end
   always_comb begin
      if (!wrapAhead)
         aheadY = pos.y;
      else if (pos.y == 10'(`V_TOTAL - 1))
         aheadY = '0;
      else
         aheadY = pos.y + 10'd1;
   end

   // Word boundary inside the visible window only
   assign strobeNext = (aheadX[3:0] == 4'd0) && (aheadX[9:4] < 6'(`WORDS_PER_ROW)) &&
                       (aheadY < 10'(`V_VISIBLE));

   // Two display lines per memory row and the roll wraps mod 256
   // column 0 of line 0 is decoded before the frame sample and keeps the old roll
   assign rowNext = aheadY[8:1] + frameRoll;

   // ==========================================================================
   // RAM port and load pulse
   // ==========================================================================

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ramRd <= 1'b0;
         load  <= 1'b0;
      end else begin
         ramRd <= strobeNext;
         load  <= ramRd;   // RAM answers one clock later
      end
   end

   always_ff @(posedge clk) begin
      if (strobeNext) begin
         ramAddr.row <= rowNext;
         ramAddr.col <= aheadX[8:4];
      end
   end

   // Word goes straight to the shifter on the load clock
   assign fetched = ramData;

   // Word lands on the clock before its first pixel or on the last clock of the line
   loadAfterRead: assert property (@(posedge clk) disable iff (!rstN)
      ramRd |=> load && ((pos.x == 10'(`H_TOTAL - 1)) || (pos.x[3:0] == 4'hf)))
      else $error("load not aligned to read at x=%0d", pos.x);

   // No read for a target line outside the window
   readLineVisible: assert property (@(posedge clk) disable iff (!rstN)
      ramRd |-> ((pos.x == 10'(`H_TOTAL - 2)) ?
                 ((pos.y == 10'(`V_TOTAL - 1)) || (pos.y < 10'(`V_VISIBLE - 1))) :
                 (pos.y < 10'(`V_VISIBLE))))
      else $error("read for invisible line at y=%0d", pos.y);

endmodule

/* shifter/pixelShifter.sv */
`include "bkVideo_params.svh"

module pixelShifter
   import bkVideoPkg::*;
(
   input  logic      clk,
   input  logic      rstN,
   input  beamPos    pos,
   input  syncBits   sync,
   input  logic      load,
   input  screenWord fetched,
   input  logic      color,
   output videoOut   video
);

   screenWord                shiftReg;
   logic                     wordVisible;
   logic                     monoBit;
   logic [1:0]               colorBits;
   rgbPixel                  decoded;
   rgbPixel                  pixelMid;
   rgbPixel                  pixelOut;
   logic [`PIPE_DELAY-1:0]   activePipe;
   syncBits [`PIPE_DELAY-2:0] syncPipe;

   // ==========================================================================
   // Word load and shift
   // ==========================================================================

   // A word loaded now is shown from the next clock
   always_comb begin
      if (pos.x == 10'(`H_TOTAL - 1))
         wordVisible = (pos.y == 10'(`V_TOTAL - 1)) || (pos.y < 10'(`V_VISIBLE - 1));
      else
         wordVisible = pos.visible && (pos.x < 10'(`H_VISIBLE - 1));
   end

   // Bit 0 always holds the pixel of the current x
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)
         shiftReg <= '0;
      else if (load)
         shiftReg <= wordVisible ? fetched : '0;
      else
         shiftReg.mono <= {1'b0, shiftReg.mono[15:1]};   // zeros drain in past the word
   end

   // ==========================================================================
   // Pixel pipeline
   // ==========================================================================

   // Stage 1 mono bit and colour field
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         monoBit   <= 1'b0;
         colorBits <= 2'b00;
      end else begin
         monoBit <= shiftReg.mono[0];
         // Field held for two clocks
         if (!pos.x[0])
            colorBits <= shiftReg.color[0];
      end
   end

   // Colour map
   always_comb begin
      if (color) begin
         case (colorBits)
            2'b01:   decoded = '{r: 1'b0, g: 1'b0, b: 1'b1};
            2'b10:   decoded = '{r: 1'b0, g: 1'b1, b: 1'b0};
            2'b11:   decoded = '{r: 1'b1, g: 1'b0, b: 1'b0};
            default: decoded = '{r: 1'b0, g: 1'b0, b: 1'b0};
         endcase
      end else begin
         // White or black
         decoded = '{r: monoBit, g: monoBit, b: monoBit};
      end
   end

   // Stages 2 and 3
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pixelMid <= '0;
         pixelOut <= '0;
      end else begin
         pixelMid <= decoded;
         pixelOut <= pixelMid;
      end
   end

   // ==========================================================================
   // Sync and active alignment
   // ==========================================================================

   // Sync arrives one clock late already
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         activePipe <= '0;
         syncPipe   <= '1;
      end else begin
         activePipe <= {activePipe[`PIPE_DELAY-2:0], pos.visible};
         syncPipe[0] <= sync;
         for (int i = 1; i < `PIPE_DELAY - 1; i++) begin
            syncPipe[i] <= syncPipe[i-1];
         end
      end
   end

   assign video = '{pixel:  pixelOut,
                    sync:   syncPipe[`PIPE_DELAY-2],
                    active: activePipe[`PIPE_DELAY-1]};

   // Drained shifter keeps the border black
   blackWhenInactive: assert property (@(posedge clk) disable iff (!rstN)
      !video.active |-> (video.pixel == '0))
      else $error("pixel not black outside window");

   // Odd load clock keeps colour capture on even x
   loadOnOddX: assert property (@(posedge clk) disable iff (!rstN)
      load |-> pos.x[0])
      else $error("load on even x=%0d", pos.x);

endmodule
